// ==== mem_subsystem.f ====
hw/sdram_pkg.sv
hw/refresh_timer.sv
hw/mem_controller.sv
hw/sdram_seq.sv
hw/mem_subsystem.sv
tb/sdram_model.sv
tb/mem_subsystem_checker.sv
tb/mem_subsystem_tb.sv

// ==== tb/mem_subsystem_tb.sv ====
// One host op at a time over a 16-word window, checked against a byte-masked reference memory.
// Unwritten words are expected as {11'h5a5, addr}, the fill of the SDRAM model.
`default_nettype none

module mem_subsystem_tb
    import sdram_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int WINDOW  = 16;
    localparam int NUM_OPS = 300;
    localparam int TIMEOUT = 400;              // cycles per wait

    logic              clk = 1'b0;
    logic              resetn;
    logic              read_a;
    logic              read_b;
    logic              write;
    mem_req_t          req;
    logic [DATA_W-1:0] dout_a;
    logic [DATA_W-1:0] dout_b;
    logic              busy;
    logic              mem_initialized;
    logic              fail;
    logic [19:0]       total_written;
    sdram_pins_t       sdram_pins;
    logic              sdram_clk;
    wire  [DATA_W-1:0] sdram_dq;
    int                refresh_count;
    int                model_errors;

    logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
    int cycle = 0;
    int init_cycle = 0;
    int writes_issued = 0;
    int mismatches = 0;
    int timeouts = 0;
    int other_errors = 0;
    bit idle_busy_seen = 1'b0;

    mem_subsystem uut (.*);

    sdram_model u_sdram_model (
        .sdram_clk     (sdram_clk),
        .pins          (sdram_pins),
        .dq            (sdram_dq),
        .refresh_count (refresh_count),
        .error_count   (model_errors)
    );

    bind mem_subsystem mem_subsystem_checker u_checker (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [ADDR_W-1:0] window_addr(input int idx);
        return {idx[3:2], 10'd0, idx[1], 7'd0, idx[0]};   // spans banks, rows, columns
    endfunction

    function automatic logic [DATA_W-1:0] stored_word(input logic [ADDR_W-1:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return {11'h5a5, addr};
    endfunction

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                   input logic [DATA_W-1:0] exp);
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        mismatches++;
    endtask

    task automatic wait_not_busy(input string what);
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("Timeout at %0t ns: busy still high %s", $time, what);
            timeouts++;
        end
    endtask

    // kind 0 is a write, 1 a read_a, 2 a read_b
    task automatic issue_op(input int kind, input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] prev_a;
        logic [DATA_W-1:0] prev_b;
        int                refreshes;
        int                lat;
        int                exp_lat;
        wait_not_busy("before a strobe");
        word = stored_word(addr);
        prev_a = dout_a;
        prev_b = dout_b;
        refreshes = refresh_count;
        req.addr = addr;
        req.wdata = $urandom;
        req.mask = MASK_W'($urandom);
        write = (kind == 0);
        read_a = (kind == 1);
        read_b = (kind == 2);
        @(negedge clk);                        // accepting edge is behind us
        write = 1'b0;
        read_a = 1'b0;
        read_b = 1'b0;
        if (!busy) begin
            $display("Error at %0t ns: busy did not rise after a strobe", $time);
            other_errors++;
        end
        if (kind == 0) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (!req.mask[b]) begin
                    word[8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
            ref_mem[addr] = word;
            writes_issued++;
            if (total_written !== 20'(writes_issued)) begin
                report_mismatch("total_written", total_written, writes_issued);
            end
        end
        exp_lat = (kind == 0) ? WRITE_LATENCY + 1 : READ_LATENCY + 1;
        lat = 0;
        while (busy && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
            if (lat == READ_LATENCY) begin
                if (dout_a !== prev_a) begin
                    report_mismatch("dout_a early", dout_a, prev_a);
                end
                if (dout_b !== prev_b) begin
                    report_mismatch("dout_b early", dout_b, prev_b);
                end
            end
            if (lat == READ_LATENCY + 1) begin
                if (dout_a !== ((kind == 1) ? word : prev_a)) begin
                    report_mismatch("dout_a", dout_a, (kind == 1) ? word : prev_a);
                end
                if (dout_b !== ((kind == 2) ? word : prev_b)) begin
                    report_mismatch("dout_b", dout_b, (kind == 2) ? word : prev_b);
                end
            end
        end
        if (busy) begin
            $display("Timeout at %0t ns: busy stuck high after a strobe", $time);
            timeouts++;
        end else if (lat < exp_lat || (lat > exp_lat && refresh_count == refreshes)) begin
            report_mismatch("busy fall cycle", lat, exp_lat);   // a refresh may stretch it
        end
    endtask

    initial begin
        int kind;
        int min_refresh;
        int total;
        void'($urandom(32'h54de_d881));
        resetn = 1'b0;
        read_a = 1'b0;
        read_b = 1'b0;
        write = 1'b0;
        req = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        if (busy !== 1'b1) begin
            report_mismatch("busy", busy, 1);
        end
        if (mem_initialized !== 1'b0) begin
            report_mismatch("mem_initialized", mem_initialized, 0);
        end
        for (int n = 0; n < TIMEOUT && mem_initialized !== 1'b1; n++) begin
            @(negedge clk);
        end
        if (mem_initialized !== 1'b1) begin
            $display("Timeout at %0t ns: mem_initialized never rose", $time);
            timeouts++;
        end else if (busy !== 1'b0) begin
            report_mismatch("busy", busy, 0);
        end
        init_cycle = cycle;

        for (int i = 0; i < NUM_OPS; i++) begin
            kind = $urandom_range(2, 0);
            issue_op(kind, window_addr($urandom_range(WINDOW - 1, 0)));
            repeat ($urandom_range(3, 0)) @(negedge clk);
        end

        // no strobes for longer than a refresh interval
        for (int n = 0; n < REFRESH_INTERVAL + 20; n++) begin
            @(negedge clk);
            if (busy) begin
                idle_busy_seen = 1'b1;
            end
        end
        if (!idle_busy_seen) begin
            $display("Error at %0t ns: busy never rose while the host was idle", $time);
            other_errors++;
        end
        for (int idx = 0; idx < WINDOW; idx++) begin
            issue_op(1 + idx % 2, window_addr(idx));
        end
        wait_not_busy("at the end of the run");

        if (total_written !== 20'(writes_issued)) begin
            report_mismatch("total_written", total_written, writes_issued);
        end
        if (fail !== 1'b0) begin
            report_mismatch("fail", fail, 0);
        end
        min_refresh = (cycle - init_cycle) / REFRESH_INTERVAL - 1;
        if (refresh_count < min_refresh) begin
            $display("Error: %0d refreshes seen, at least %0d expected", refresh_count,
                     min_refresh);
            other_errors++;
        end
        total = mismatches + timeouts + other_errors + model_errors
                + uut.u_checker.assert_failures;
        $display("Errors: %0d mismatches, %0d timeouts, %0d other, %0d model, %0d assertions",
                 mismatches, timeouts, other_errors, model_errors,
                 uut.u_checker.assert_failures);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/mem_subsystem_checker.sv ====
// Protocol assertions bound into mem_subsystem, sampled on clk and off while resetn is low.
`default_nettype none

module mem_subsystem_checker
    import sdram_pkg::*;
(
    input logic        clk,
    input logic        resetn,
    input logic        read_a,
    input logic        read_b,
    input logic        write,
    input logic        busy,
    input logic        fail,
    input sdram_pins_t sdram_pins
);
    timeunit 1ns;
    timeprecision 1ns;

    int         assert_failures = 0;   // read by the testbench at the end
    logic [3:0] cmd;
    logic       is_rw;

    assign cmd = {sdram_pins.cs_n, sdram_pins.ras_n, sdram_pins.cas_n, sdram_pins.we_n};
    assign is_rw = (cmd == CMD_READ) || (cmd == CMD_WRITE);

    // no READ or WRITE on a bank less than T_RCD cycles after its ACTIVE
    for (genvar k = 1; k < T_RCD; k++) begin : g_rcd
        a_rcd: assert property (@(posedge clk) disable iff (!resetn)
            is_rw |-> !($past(cmd, k) == CMD_ACTIVE && $past(sdram_pins.ba, k) == sdram_pins.ba))
            else begin
                assert_failures++;
                $error("READ or WRITE issued too soon after ACTIVE");
            end
    end

    a_cke_nop: assert property (@(posedge clk) disable iff (!resetn)
        !sdram_pins.cke |-> cmd == CMD_NOP)
        else begin
            assert_failures++;
            $error("command other than NOP while cke is low");
        end

    a_busy_after_accept: assert property (@(posedge clk) disable iff (!resetn)
        (!busy && (read_a || read_b || write)) |=> busy)
        else begin
            assert_failures++;
            $error("busy low in the cycle after an accepted strobe");
        end

    a_no_fail: assert property (@(posedge clk) disable iff (!resetn) !fail)
        else begin
            assert_failures++;
            $error("fail flag raised");
        end

endmodule

`default_nettype wire

// ==== tb/sdram_model.sv ====
// Behavioral x32 SDRAM for single-word accesses. Unwritten words read as {11'h5a5, addr}.
// Read data is valid during the cycle that ends CAS_LAT sdram_clk edges after the READ.
`default_nettype none

module sdram_model
    import sdram_pkg::*;
(
    input  wire               sdram_clk,
    input  sdram_pins_t       pins,
    inout  wire  [DATA_W-1:0] dq,
    output int                refresh_count,
    output int                error_count
);
    timeunit 1ns;
    timeprecision 1ns;

    localparam int BANKS = 1 << BANK_W;

    logic [DATA_W-1:0]  mem [logic [ADDR_W-1:0]];
    logic [ROW_W-1:0]   open_row [BANKS];
    logic [BANKS-1:0]   row_open = '0;
    logic               mode_set = 1'b0;       // load mode seen, init over
    logic [CAS_LAT-1:0] rd_v = '0;
    logic [DATA_W-1:0]  rd_d [CAS_LAT];
    logic [3:0]         cmd;

    assign cmd = {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n};
    assign dq = rd_v[CAS_LAT-1] ? rd_d[CAS_LAT-1] : {DATA_W{1'bz}};

    initial begin
        refresh_count = 0;
        error_count = 0;
    end

    task automatic protocol_error(input string what);
        $display("SDRAM model error at %0t ns: %s", $time, what);
        error_count++;
    endtask

    always @(posedge sdram_clk) begin
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] word;
        rd_v <= rd_v << 1;                     // read data pipeline
        for (int i = CAS_LAT - 1; i > 0; i--) begin
            rd_d[i] <= rd_d[i-1];
        end
        if (pins.cke === 1'b1) begin
            case (cmd)
                CMD_ACTIVE: begin
                    if (!mode_set) begin
                        protocol_error("ACTIVE before init finished");
                    end
                    if (row_open[pins.ba]) begin
                        protocol_error("ACTIVE to a bank that has an open row");
                    end
                    open_row[pins.ba] = pins.a;
                    row_open[pins.ba] = 1'b1;
                end
                CMD_READ, CMD_WRITE: begin
                    if (!mode_set || !row_open[pins.ba]) begin
                        protocol_error("READ or WRITE before init or to a closed bank");
                    end
                    addr = {pins.ba, open_row[pins.ba], pins.a[COL_W-1:0]};
                    word = mem.exists(addr) ? mem[addr] : {11'h5a5, addr};
                    if (cmd == CMD_READ) begin
                        rd_v[0] <= 1'b1;
                        rd_d[0] <= word;
                    end else begin
                        for (int b = 0; b < MASK_W; b++) begin
                            if (!pins.dqm[b]) begin
                                word[8*b +: 8] = dq[8*b +: 8];   // dqm high keeps the byte
                            end
                        end
                        mem[addr] = word;
                    end
                    if (pins.a[10]) begin
                        row_open[pins.ba] = 1'b0;     // auto-precharge
                    end
                end
                CMD_PRECHARGE: begin
                    if (pins.a[10]) begin
                        row_open = '0;
                    end else begin
                        row_open[pins.ba] = 1'b0;
                    end
                end
                CMD_REFRESH: begin
                    if (row_open != '0) begin
                        protocol_error("AUTO REFRESH with a bank still open");
                    end
                    if (mode_set) begin
                        refresh_count++;              // init refreshes not counted
                    end
                end
                CMD_LOAD_MODE: begin
                    if (pins.a[6:4] != 3'(CAS_LAT)) begin
                        protocol_error("mode register holds the wrong CAS latency");
                    end
                    mode_set = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_subsystem.sv ====
// Host side strobes plus one SDRAM chip. Wait for busy low before every strobe.
`default_nettype none

module mem_subsystem
    import sdram_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              read_a,
    input  logic              read_b,
    input  logic              write,
    input  mem_req_t          req,
    output logic [DATA_W-1:0] dout_a,
    output logic [DATA_W-1:0] dout_b,
    output logic              busy,
    output logic              mem_initialized,
    output logic              fail,
    output logic [19:0]       total_written,
    output sdram_pins_t       sdram_pins,
    output logic              sdram_clk,
    inout  wire  [DATA_W-1:0] sdram_dq
);

    logic              refresh_pend;
    logic              refresh_grant;
    logic              seq_ready;
    logic              init_done;
    logic              rdata_valid;
    logic [DATA_W-1:0] rdata;
    mem_op_e           op;
    mem_req_t          op_req;

    refresh_timer u_refresh_timer (
        .clk           (clk),
        .resetn        (resetn),
        .enable        (mem_initialized),     // no refresh requests during init
        .refresh_grant (refresh_grant),
        .refresh_pend  (refresh_pend)
    );

    mem_controller u_mem_controller (
        .clk             (clk),
        .resetn          (resetn),
        .read_a          (read_a),
        .read_b          (read_b),
        .write           (write),
        .req             (req),
        .refresh_pend    (refresh_pend),
        .seq_ready       (seq_ready),
        .init_done       (init_done),
        .rdata_valid     (rdata_valid),
        .rdata           (rdata),
        .op              (op),
        .op_req          (op_req),
        .refresh_grant   (refresh_grant),
        .busy            (busy),
        .mem_initialized (mem_initialized),
        .fail            (fail),
        .dout_a          (dout_a),
        .dout_b          (dout_b),
        .total_written   (total_written)
    );

    sdram_seq u_sdram_seq (
        .clk         (clk),
        .resetn      (resetn),
        .op          (op),
        .req         (op_req),
        .seq_ready   (seq_ready),
        .init_done   (init_done),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .pins        (sdram_pins),
        .sdram_clk   (sdram_clk),
        .dq          (sdram_dq)
    );

endmodule

`default_nettype wire

// ==== hw/sdram_seq.sv ====
// Single-word accesses with auto-precharge, no open rows. Commands launch on clk rise,
// the SDRAM sees ~clk, and read data is taken CAS_LAT clk edges after the READ launch.
`default_nettype none

module sdram_seq
    import sdram_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  mem_op_e           op,
    input  mem_req_t          req,
    output logic              seq_ready,
    output logic              init_done,
    output logic              rdata_valid,
    output logic [DATA_W-1:0] rdata,
    output sdram_pins_t       pins,
    output logic              sdram_clk,
    inout  wire  [DATA_W-1:0] dq
);

    typedef enum logic [3:0] {
        ST_INIT_WAIT,
        ST_INIT_PRE,
        ST_INIT_REF1,
        ST_INIT_REF2,
        ST_INIT_MRS,
        ST_IDLE,
        ST_RCD,
        ST_CAS,
        ST_WAIT
    } state_e;

    typedef logic [$clog2(INIT_CYCLES)-1:0] cnt_t;

    state_e            state;
    cnt_t              cnt;
    logic              last;
    logic              wr_q;                  // access in flight is a write
    logic              dq_oe;
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    logic [ROW_W-1:0]  a10_set;
    logic [ROW_W-1:0]  col_ap;
    logic [ROW_W-1:0]  mode_word;

    function automatic sdram_pins_t make_pins(
        input logic [3:0]        cmd,
        input logic [BANK_W-1:0] ba,
        input logic [ROW_W-1:0]  a,
        input logic [MASK_W-1:0] dqm
    );
        sdram_pins_t p;
        p.cke = 1'b1;
        {p.cs_n, p.ras_n, p.cas_n, p.we_n} = cmd;
        p.ba = ba;
        p.a = a;
        p.dqm = dqm;
        return p;
    endfunction

    assign sdram_clk = ~clk;                  // SDRAM samples mid-cycle
    assign seq_ready = (state == ST_IDLE);
    assign last = (cnt == '0);

    // req stays latched in the controller for the whole access
    assign bank = req.addr[ADDR_W-1 -: BANK_W];
    assign row = req.addr[COL_W +: ROW_W];
    assign a10_set = {1'b1, {(ROW_W-1){1'b0}}};
    assign col_ap = a10_set | ROW_W'(req.addr[COL_W-1:0]);
    assign mode_word = ROW_W'({3'(CAS_LAT), 4'b0000});  // sequential, burst length 1

    assign dq = dq_oe ? req.wdata : {DATA_W{1'bz}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_INIT_WAIT;
            cnt <= cnt_t'(INIT_CYCLES - 1);
            pins <= make_pins(CMD_NOP, '0, '0, '0);
            init_done <= 1'b0;
            rdata_valid <= 1'b0;
            dq_oe <= 1'b0;
            wr_q <= 1'b0;
        end else begin
            pins <= make_pins(CMD_NOP, '0, '0, '0);
            rdata_valid <= 1'b0;
            dq_oe <= 1'b0;
            if (!last) begin
                cnt <= cnt - 1'b1;
            end

            case (state)
                ST_INIT_WAIT: begin
                    if (last) begin
                        pins <= make_pins(CMD_PRECHARGE, '0, a10_set, '0);  // all banks
                        cnt <= cnt_t'(T_RP - 1);
                        state <= ST_INIT_PRE;
                    end
                end
                ST_INIT_PRE: begin
                    if (last) begin
                        pins <= make_pins(CMD_REFRESH, '0, '0, '0);
                        cnt <= cnt_t'(T_RC - 1);
                        state <= ST_INIT_REF1;
                    end
                end
                ST_INIT_REF1: begin
                    if (last) begin
                        pins <= make_pins(CMD_REFRESH, '0, '0, '0);
                        cnt <= cnt_t'(T_RC - 1);
                        state <= ST_INIT_REF2;
                    end
                end
                ST_INIT_REF2: begin
                    if (last) begin
                        pins <= make_pins(CMD_LOAD_MODE, '0, mode_word, '0);
                        cnt <= cnt_t'(1);             // tMRD of 2 cycles
                        state <= ST_INIT_MRS;
                    end
                end
                ST_INIT_MRS: begin
                    if (last) begin
                        init_done <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    case (op)
                        OP_READ, OP_WRITE: begin
                            pins <= make_pins(CMD_ACTIVE, bank, row, '0);
                            wr_q <= (op == OP_WRITE);
                            cnt <= cnt_t'(T_RCD - 1);
                            state <= ST_RCD;
                        end
                        OP_REFRESH: begin
                            pins <= make_pins(CMD_REFRESH, '0, '0, '0);
                            cnt <= cnt_t'(T_RC - 1);
                            state <= ST_WAIT;
                        end
                        default: ;
                    endcase
                end
                ST_RCD: begin
                    if (last && wr_q) begin
                        // data and byte mask go out with the command
                        pins <= make_pins(CMD_WRITE, bank, col_ap, req.mask);
                        dq_oe <= 1'b1;
                        cnt <= cnt_t'(T_WR);
                        state <= ST_WAIT;
                    end else if (last) begin
                        pins <= make_pins(CMD_READ, bank, col_ap, '0);
                        cnt <= cnt_t'(CAS_LAT - 1);
                        state <= ST_CAS;
                    end
                end
                ST_CAS: begin
                    if (last) begin
                        rdata_valid <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                ST_WAIT: begin
                    if (last) begin
                        state <= ST_IDLE;             // write recovery or tRC done
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // capture read word in the same edge that raises rdata_valid
    always_ff @(posedge clk) begin
        if (state == ST_CAS && last) begin
            rdata <= dq;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_controller.sv ====
// Strobes are taken only while busy is low; there is no queue and no handshake.
// Completion is timed by a fixed cycle count, and late or stray read data sets fail.
`default_nettype none

module mem_controller
    import sdram_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              read_a,
    input  logic              read_b,
    input  logic              write,
    input  mem_req_t          req,
    input  logic              refresh_pend,
    input  logic              seq_ready,
    input  logic              init_done,
    input  logic              rdata_valid,
    input  logic [DATA_W-1:0] rdata,
    output mem_op_e           op,
    output mem_req_t          op_req,
    output logic              refresh_grant,
    output logic              busy,
    output logic              mem_initialized,
    output logic              fail,
    output logic [DATA_W-1:0] dout_a,
    output logic [DATA_W-1:0] dout_b,
    output logic [19:0]       total_written
);

    typedef logic [$clog2(WRITE_LATENCY+1)-1:0] wait_t;

    logic  busy_r;
    wait_t wait_cnt;                          // cycles to expected completion
    logic  rd_a_q;
    logic  rd_b_q;
    logic  idle;
    logic  start_refresh;
    logic  accept;
    logic  op_done;
    logic  read_done;

    // pending refresh shows up as busy before it is granted
    assign busy = busy_r | refresh_pend;

    assign idle = mem_initialized & ~busy_r & seq_ready;
    assign start_refresh = idle & refresh_pend;
    assign accept = idle & ~refresh_pend & (read_a | read_b | write);
    assign op_done = mem_initialized & busy_r & (wait_cnt == '0);
    assign read_done = op_done & (rd_a_q | rd_b_q);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_r <= 1'b1;
            mem_initialized <= 1'b0;
            fail <= 1'b0;
            total_written <= '0;
            op <= OP_NONE;
            refresh_grant <= 1'b0;
            wait_cnt <= '0;
            rd_a_q <= 1'b0;
            rd_b_q <= 1'b0;
        end else begin
            op <= OP_NONE;
            refresh_grant <= 1'b0;
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end

            if (!mem_initialized) begin
                if (init_done) begin
                    mem_initialized <= 1'b1;
                    busy_r <= 1'b0;
                end
            end else if (start_refresh) begin
                op <= OP_REFRESH;
                refresh_grant <= 1'b1;
                busy_r <= 1'b1;
                wait_cnt <= wait_t'(REFRESH_LATENCY);
            end else if (accept && (read_a || read_b)) begin
                op <= OP_READ;
                busy_r <= 1'b1;
                wait_cnt <= wait_t'(READ_LATENCY);
                rd_a_q <= read_a;             // remember which port asked
                rd_b_q <= read_b;
            end else if (accept) begin
                op <= OP_WRITE;
                busy_r <= 1'b1;
                wait_cnt <= wait_t'(WRITE_LATENCY);
                total_written <= total_written + 20'd1;
            end else if (op_done) begin
                busy_r <= 1'b0;
                rd_a_q <= 1'b0;
                rd_b_q <= 1'b0;
            end

            // read data must land exactly in the completion cycle
            if (rdata_valid ^ read_done) begin
                fail <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_req <= req;
        end
        if (read_done && rd_a_q) begin
            dout_a <= rdata;
        end
        if (read_done && rd_b_q) begin
            dout_b <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/refresh_timer.sv ====
// Counts only while enabled; a pending request is held, never queued twice.
`default_nettype none

module refresh_timer
    import sdram_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  logic enable,
    input  logic refresh_grant,
    output logic refresh_pend
);

    typedef logic [$clog2(REFRESH_INTERVAL)-1:0] count_t;

    count_t count;
    logic   wrap;

    assign wrap = enable && (count == count_t'(REFRESH_INTERVAL - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
            refresh_pend <= 1'b0;
        end else begin
            if (wrap) begin
                count <= '0;
            end else if (enable) begin
                count <= count + 1'b1;
            end
            // a wrap in the grant cycle keeps the request alive
            if (wrap) begin
                refresh_pend <= 1'b1;
            end else if (refresh_grant) begin
                refresh_pend <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/sdram_pkg.sv ====
// Shared widths, timing and types for the single-chip 32-bit SDRAM subsystem.
// Timing values are in clk cycles and kept small for short simulations.
`default_nettype none

package sdram_pkg;

    // word address is {bank, row, column}
    localparam int COL_W  = 8;
    localparam int ROW_W  = 11;
    localparam int BANK_W = 2;
    localparam int ADDR_W = BANK_W + ROW_W + COL_W;
    localparam int DATA_W = 32;
    localparam int MASK_W = DATA_W / 8;        // 1 = byte not written

    localparam int T_RCD            = 2;
    localparam int CAS_LAT          = 2;
    localparam int T_WR             = 2;
    localparam int T_RP             = 2;
    localparam int T_RC             = 6;
    localparam int INIT_CYCLES      = 20;      // power-up wait
    localparam int REFRESH_INTERVAL = 200;

    // cycles from op issue until the sequencer is done
    localparam int READ_LATENCY    = T_RCD + CAS_LAT + 1;
    localparam int WRITE_LATENCY   = T_RCD + 1 + T_WR + 1;
    localparam int REFRESH_LATENCY = T_RC;

    // command codes as {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] CMD_NOP       = 4'b0111;
    localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
    localparam logic [3:0] CMD_READ      = 4'b0101;
    localparam logic [3:0] CMD_WRITE     = 4'b0100;
    localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
    localparam logic [3:0] CMD_REFRESH   = 4'b0001;
    localparam logic [3:0] CMD_LOAD_MODE = 4'b0000;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE,
        OP_REFRESH
    } mem_op_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [MASK_W-1:0] mask;
    } mem_req_t;

    typedef struct packed {
        logic              cke;
        logic              cs_n;
        logic              ras_n;
        logic              cas_n;
        logic              we_n;
        logic [BANK_W-1:0] ba;
        logic [ROW_W-1:0]  a;
        logic [MASK_W-1:0] dqm;
    } sdram_pins_t;

endpackage

`default_nettype wire
